//--- design/pio_params.svh
`ifndef PIO_PARAMS_SVH
`define PIO_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// flag pin side.
// ~~~~~~~~~~~~~~~~~~~~

// one bit per flag pin.
`define PIO_WIDTH 12

// ~~~~~~~~~~~~~~~~~~~~
// host side.
// ~~~~~~~~~~~~~~~~~~~~

// host data bus, bits 11:8 unused by the flag images.
`define DMD_WIDTH 16

`define CMD_DEPTH 4 // queued commands, power of two.

`endif

//--- design/pioRegPkg.sv
`include "pio_params.svh"

package pioRegPkg;

  // flag register select.
  typedef enum logic [1:0]
  {
    REG_MASK,
    REG_INT,
    REG_TYPE,
    REG_DATA
  } pioReg;

  // 12-bit image onto the 16-bit bus, hole at 11:8.
  function automatic logic [`DMD_WIDTH-1:0] toBus(input logic [`PIO_WIDTH-1:0] img);
    return {img[11:8], 4'b0000, img[7:0]};
  endfunction

  function automatic logic [`PIO_WIDTH-1:0] fromBus(input logic [`DMD_WIDTH-1:0] bus);
    return {bus[15:12], bus[7:0]};
  endfunction

endpackage

//--- design/hostCmdPkg.sv
package hostCmdPkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // host command opcodes.
  // ~~~~~~~~~~~~~~~~~~~~
  typedef enum logic
  {
    OP_WRITE,
    OP_READ
  } hostOp;

  // ~~~~~~~~~~~~~~~~~~~~
  // register access sequencer.
  // ~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [2:0]
  {
    IDLE,    // waiting on the FIFO.
    POP,     // head taken.
    ISSUE,   // strobe or read select.
    RESP_HI, // rspReq up, wait for rspAck.
    RESP_LO  // wait for rspAck to drop.
  } seqState;

endpackage

//--- design/hostCmdCapture.sv
`include "pio_params.svh"

module hostCmdCapture
(
  input  logic                  PIOCLK0,
  input  logic                  T_RST,
  input  logic                  hostReq,
  input  hostCmdPkg::hostOp     hostOp,
  input  pioRegPkg::pioReg      hostReg,
  input  logic [`DMD_WIDTH-1:0] hostData,
  output logic                  hostAck,
  input  logic                  full,
  output logic                  push,
  output hostCmdPkg::hostOp     pushOp,
  output pioRegPkg::pioReg      pushReg,
  output logic [`DMD_WIDTH-1:0] pushData
);

  typedef enum logic
  {
    CAP_IDLE,
    CAP_HOLD
  } capState;

  capState state;

  // one push per request, held off while the FIFO is full.
  assign push = hostReq && (state == CAP_IDLE) && !full;
  assign hostAck = (state == CAP_HOLD);

  // fields are stable while hostReq is high.
  assign pushOp = hostOp;
  assign pushReg = hostReg;
  assign pushData = hostData;

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
      state <= CAP_IDLE;
    else
    begin
      case (state)
        CAP_IDLE:
        begin
          if (push)
            state <= CAP_HOLD; // ack rises with the push.
        end
        CAP_HOLD:
        begin
          if (!hostReq)
            state <= CAP_IDLE;
        end
        default:
          state <= CAP_IDLE;
      endcase
    end
  end

  // a request and its fields hold until the host sees hostAck.
  reqHeld: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    hostReq && !hostAck |=> hostReq && $stable(hostOp) && $stable(hostReg)
      && $stable(hostData));

endmodule

//--- design/cmdFifo.sv
`include "pio_params.svh"

module cmdFifo
(
  input  logic                  PIOCLK0,
  input  logic                  T_RST,
  input  logic                  push,
  input  hostCmdPkg::hostOp     pushOp,
  input  pioRegPkg::pioReg      pushReg,
  input  logic [`DMD_WIDTH-1:0] pushData,
  output logic                  full,
  input  logic                  pop,
  output logic                  empty,
  output hostCmdPkg::hostOp     popOp,
  output pioRegPkg::pioReg      popReg,
  output logic [`DMD_WIDTH-1:0] popData
);

  import hostCmdPkg::*;
  import pioRegPkg::*;

  localparam int DEPTH = `CMD_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);

  hostOp                 opMem   [DEPTH];
  pioReg                 regMem  [DEPTH];
  logic [`DMD_WIDTH-1:0] dataMem [DEPTH];

  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W:0]   count;

  assign full = (count == FULL_CNT);
  assign empty = (count == '0);

  // head of queue, valid whenever not empty.
  assign popOp = opMem[rdPtr];
  assign popReg = regMem[rdPtr];
  assign popData = dataMem[rdPtr];

  always_ff @(posedge PIOCLK0)
  begin
    if (push)
    begin
      opMem[wrPtr] <= pushOp;
      regMem[wrPtr] <= pushReg;
      dataMem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1; // wraps, depth is a power of two.
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  noPopEmpty: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    pop |-> !empty);

endmodule

//--- design/regAccessSeq.sv
`include "pio_params.svh"

module regAccessSeq
(
  input  logic                  PIOCLK0,
  input  logic                  T_RST,
  input  logic                  empty,
  output logic                  pop,
  input  hostCmdPkg::hostOp     popOp,
  input  pioRegPkg::pioReg      popReg,
  input  logic [`DMD_WIDTH-1:0] popData,
  output pioRegPkg::pioReg      regSel,
  output logic                  regWe,
  output logic [`DMD_WIDTH-1:0] regWrData,
  input  logic [`DMD_WIDTH-1:0] regRdData,
  output logic                  rspReq,
  input  logic                  rspAck,
  output logic [`DMD_WIDTH-1:0] rspData
);

  import hostCmdPkg::*;
  import pioRegPkg::*;

  seqState               state;
  seqState               nextState;
  hostOp                 curOp;
  pioReg                 curReg;
  logic [`DMD_WIDTH-1:0] curData;

  always_comb
  begin
    nextState = state;
    case (state)
      IDLE:    if (!empty) nextState = POP;
      POP:     nextState = ISSUE;
      ISSUE:   nextState = (curOp == OP_READ) ? RESP_HI : IDLE;
      RESP_HI: if (rspAck) nextState = RESP_LO;
      RESP_LO: if (!rspAck) nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      state <= IDLE;
      curOp <= OP_WRITE;
      curReg <= REG_MASK;
    end
    else
    begin
      state <= nextState;
      if (pop)
      begin
        curOp <= popOp;
        curReg <= popReg;
      end
    end
  end

  always_ff @(posedge PIOCLK0)
  begin
    if (pop)
      curData <= popData;
    if (state == ISSUE && curOp == OP_READ)
      rspData <= regRdData; // select has settled by now.
  end

  assign pop = (state == POP);
  assign regSel = curReg;
  assign regWe = (state == ISSUE) && (curOp == OP_WRITE); // single cycle.
  assign regWrData = curData;
  assign rspReq = (state == RESP_HI);

  // four-phase response, the host acknowledges only a pending rspReq.
  ackOnReq: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    $rose(rspAck) |-> rspReq);

endmodule

//--- design/pioFlags.sv
`include "pio_params.svh"

module pioFlags
(
  input  logic                  PIOCLK0,
  input  logic                  T_RST,
  input  pioRegPkg::pioReg      regSel,
  input  logic                  regWe,
  input  logic [`DMD_WIDTH-1:0] regWrData,
  output logic [`DMD_WIDTH-1:0] regRdData,
  input  logic [`PIO_WIDTH-1:0] pioIn,
  output logic [`PIO_WIDTH-1:0] pioOut,
  output logic [`PIO_WIDTH-1:0] pioEn,
  output logic                  pioIntN
);

  import pioRegPkg::*;

  logic [`PIO_WIDTH-1:0] pMask;
  logic [`PIO_WIDTH-1:0] pType; // 1 = output pin.
  logic [`PIO_WIDTH-1:0] pData;
  logic [`PIO_WIDTH-1:0] pInt;
  logic [`PIO_WIDTH-1:0] wrImg;
  logic [`PIO_WIDTH-1:0] inPrev;
  logic [`PIO_WIDTH-1:0] inFilt;
  logic [`PIO_WIDTH-1:0] filtNext;
  logic [`PIO_WIDTH-1:0] filtDly;
  logic [`PIO_WIDTH-1:0] intSet;
  logic                  wrMask;
  logic                  wrType;
  logic                  wrData;
  logic                  wrInt;

  assign wrImg = fromBus(regWrData);
  assign wrMask = regWe && (regSel == REG_MASK);
  assign wrType = regWe && (regSel == REG_TYPE);
  assign wrData = regWe && (regSel == REG_DATA);
  assign wrInt = regWe && (regSel == REG_INT);

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      pMask <= '0;
      pType <= '0;
    end
    else
    begin
      if (wrMask)
        pMask <= wrImg;
      if (wrType)
        pType <= wrImg;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // input filter.
  // ~~~~~~~~~~~~~~~~~~~~

  // rise needs two high samples, fall needs two low ones.
  assign filtNext = (inFilt & (pioIn | inPrev)) | (~inFilt & pioIn & inPrev);

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      inPrev <= '0;
      inFilt <= '0;
      filtDly <= '0;
    end
    else
    begin
      inPrev <= pioIn;
      inFilt <= filtNext;
      filtDly <= inFilt; // edge detect for the latch.
    end
  end

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
      pData <= '0;
    else if (wrData)
      pData <= (pType & wrImg) | (~pType & inFilt);
    else
      pData <= (pType & pData) | (~pType & inFilt);
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // interrupt latch.
  // ~~~~~~~~~~~~~~~~~~~~

  assign intSet = (inFilt ^ filtDly) & ~pType & pMask;

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
      pInt <= '0;
    else if (wrInt)
      pInt <= wrImg; // host write wins over new edges.
    else
      pInt <= pInt | intSet;
  end

  assign pioIntN = ~(|(pMask & pInt));
  assign pioOut = pData;
  assign pioEn = pType;

  always_comb
  begin
    case (regSel)
      REG_MASK: regRdData = toBus(pMask);
      REG_INT:  regRdData = toBus(pInt);
      REG_TYPE: regRdData = toBus(pType);
      default:  regRdData = toBus(pData);
    endcase
  end

endmodule

//--- design/pioTop.sv
`include "pio_params.svh"

module pioTop
(
  input  logic                  PIOCLK0,
  input  logic                  T_RST,
  input  logic                  hostReq,
  input  hostCmdPkg::hostOp     hostOp,
  input  pioRegPkg::pioReg      hostReg,
  input  logic [`DMD_WIDTH-1:0] hostData,
  output logic                  hostAck,
  output logic                  rspReq,
  input  logic                  rspAck,
  output logic [`DMD_WIDTH-1:0] rspData,
  input  logic [`PIO_WIDTH-1:0] pioIn,
  output logic [`PIO_WIDTH-1:0] pioOut,
  output logic [`PIO_WIDTH-1:0] pioEn,
  output logic                  pioIntN
);

  import pioRegPkg::*;

  // ~~~~~~~~~~~~~~~~~~~~
  // command path.
  // ~~~~~~~~~~~~~~~~~~~~
  logic                  push;
  hostCmdPkg::hostOp     pushOp;
  pioReg                 pushReg;
  logic [`DMD_WIDTH-1:0] pushData;
  logic                  full;
  logic                  pop;
  logic                  empty;
  hostCmdPkg::hostOp     popOp;
  pioReg                 popReg;
  logic [`DMD_WIDTH-1:0] popData;

  // register side.
  pioReg                 regSel;
  logic                  regWe;
  logic [`DMD_WIDTH-1:0] regWrData;
  logic [`DMD_WIDTH-1:0] regRdData;

  hostCmdCapture uCapture (.PIOCLK0, .T_RST, .hostReq, .hostOp, .hostReg, .hostData,
    .hostAck, .full, .push, .pushOp, .pushReg, .pushData);

  cmdFifo uFifo (.PIOCLK0, .T_RST, .push, .pushOp, .pushReg, .pushData, .full,
    .pop, .empty, .popOp, .popReg, .popData);

  regAccessSeq uSeq (.PIOCLK0, .T_RST, .empty, .pop, .popOp, .popReg, .popData,
    .regSel, .regWe, .regWrData, .regRdData, .rspReq, .rspAck, .rspData);

  pioFlags uFlags (.PIOCLK0, .T_RST, .regSel, .regWe, .regWrData, .regRdData,
    .pioIn, .pioOut, .pioEn, .pioIntN);

endmodule

//--- verif/pioTbChecks.sv
`include "pio_params.svh"

module pioTbChecks
(
  input  logic                  PIOCLK0,
  input  logic                  T_RST,
  input  logic                  hostReq,
  input  logic                  hostAck,
  input  logic                  rspReq,
  input  logic                  rspAck,
  input  logic [`DMD_WIDTH-1:0] rspData,
  input  logic [`PIO_WIDTH-1:0] pioOut,
  input  logic [`PIO_WIDTH-1:0] pioEn,
  input  logic                  pioIntN,
  input  hostCmdPkg::seqState   seqSt,
  input  logic [`DMD_WIDTH-1:0] expRsp,
  input  logic [`PIO_WIDTH-1:0] expEn,
  input  logic [`PIO_WIDTH-1:0] expOut,
  input  logic                  expIntN,
  input  logic                  expStall,
  output int                    valErrors,
  output int                    protoErrors
);

  import hostCmdPkg::*;

  int   valCount = 0;
  int   protoCount = 0;
  logic rspSeen;

  assign valErrors = valCount;
  assign protoErrors = protoCount;
  assign rspSeen = rspReq && rspAck; // host has taken the response.

  task automatic protocolFault(input string what);
    protoCount++;
    $display("%0t: %s", $time, what);
  endtask

  task automatic valueMismatch(input string name, input logic [15:0] exp, input logic [15:0] got);
    valCount++;
    $display("error %0t %s expected %h got %h", $time, name, exp, got);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // reset and handshakes.
  // ~~~~~~~~~~~~~~~~~~~~
  rstIdle: assert property (@(posedge PIOCLK0) T_RST |=>
    !hostAck && !rspReq && pioIntN && pioEn == '0 && pioOut == '0)
    else protocolFault("outputs were not idle during or right after reset");
  reqOverAck: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    $rose(hostReq) |-> !hostAck) else protocolFault("hostReq rose while hostAck was high");
  ackWithReq: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    $rose(hostAck) |-> hostReq) else protocolFault("hostAck rose with no request pending");
  ackHeld: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    hostReq && hostAck |=> hostAck) else protocolFault("hostAck fell while hostReq was high");
  ackRelease: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    !hostReq && hostAck |=> !hostAck) else protocolFault("hostAck stayed high after hostReq fell");
  rspDropEarly: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    $fell(rspReq) |-> $past(rspAck)) else protocolFault("rspReq fell before rspAck rose");
  rspState: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    rspAck |-> seqSt inside {RESP_HI, RESP_LO})
    else protocolFault("sequencer left the response states while rspAck was high");
  fullStall: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    expStall |-> !hostAck) else protocolFault("hostAck rose while the command FIFO was full");

  // ~~~~~~~~~~~~~~~~~~~~
  // response values.
  // ~~~~~~~~~~~~~~~~~~~~
  rspValue: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    rspSeen |-> rspData == expRsp)
    else valueMismatch("rspData", $sampled(expRsp), $sampled(rspData));
  enValue: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    rspSeen |-> pioEn == expEn)
    else valueMismatch("pioEn", 16'($sampled(expEn)), 16'($sampled(pioEn)));
  outValue: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    rspSeen |-> pioOut == expOut)
    else valueMismatch("pioOut", 16'($sampled(expOut)), 16'($sampled(pioOut)));
  intValue: assert property (@(posedge PIOCLK0) disable iff (T_RST)
    rspSeen |-> pioIntN == expIntN)
    else valueMismatch("pioIntN", 16'($sampled(expIntN)), 16'($sampled(pioIntN)));

endmodule

//--- verif/pioTb.sv
`include "pio_params.svh"

module pioTb;

  import pioRegPkg::*;

  localparam int STIM_CYCLES = 600;
  localparam int MARGIN = 1600;

  logic                  PIOCLK0 = 1'b0;
  logic                  T_RST = 1'b1;
  logic                  hostReq = 1'b0;
  hostCmdPkg::hostOp     hostOp = hostCmdPkg::OP_WRITE;
  pioReg                 hostReg = REG_MASK;
  logic [`DMD_WIDTH-1:0] hostData = '0;
  logic                  hostAck;
  logic                  rspReq;
  logic                  rspAck = 1'b0;
  logic [`DMD_WIDTH-1:0] rspData;
  logic [`PIO_WIDTH-1:0] pioIn = '0;
  logic [`PIO_WIDTH-1:0] pioOut;
  logic [`PIO_WIDTH-1:0] pioEn;
  logic                  pioIntN;

  // ~~~~~~~~~~~~~~~~~~~~
  // register model.
  // ~~~~~~~~~~~~~~~~~~~~
  logic [`PIO_WIDTH-1:0] mMask = '0;
  logic [`PIO_WIDTH-1:0] mType = '0;
  logic [`PIO_WIDTH-1:0] mData = '0;
  logic [`PIO_WIDTH-1:0] mInt = '0;
  logic [`PIO_WIDTH-1:0] mPins = '0; // held pin level.
  logic [40:0]           expQ [$];   // {intN, en, out, rsp} per read, in order.
  logic [`DMD_WIDTH-1:0] expRsp = '0;
  logic [`PIO_WIDTH-1:0] expEn = '0;
  logic [`PIO_WIDTH-1:0] expOut = '0;
  logic                  expIntN = 1'b1;
  logic                  expStall = 1'b0;
  logic                  ackEnable = 1'b1;
  int                    seed = 82342;
  int                    tbErrors = 0;
  int                    valErrors;
  int                    protoErrors;

  pioTop DUT (.*);

  pioTbChecks checks (.*, .seqSt(DUT.uSeq.state));

  always #4 PIOCLK0 = ~PIOCLK0;

  function automatic logic [`DMD_WIDTH-1:0] busImage(input logic [`PIO_WIDTH-1:0] img);
    return {img[11:8], 4'h0, img[7:0]};
  endfunction

  task automatic completeRequest();
    @(posedge PIOCLK0);
    while (!hostAck) @(posedge PIOCLK0);
    hostReq <= 1'b0;
    @(posedge PIOCLK0);
    while (hostAck) @(posedge PIOCLK0);
  endtask

  task automatic hostWrite(input pioReg r, input logic [`DMD_WIDTH-1:0] d);
    logic [`PIO_WIDTH-1:0] img;
    img = {d[15:12], d[7:0]};
    case (r)
      REG_MASK: mMask = img;
      REG_INT:  mInt = img;
      REG_TYPE:
      begin
        mType = img;
        mData = (mType & mData) | (~mType & mPins); // new inputs follow the pins.
      end
      default:  mData = (mType & img) | (~mType & mPins);
    endcase
    @(posedge PIOCLK0);
    hostReq <= 1'b1;
    hostOp <= hostCmdPkg::OP_WRITE;
    hostReg <= r;
    hostData <= d;
    completeRequest();
  endtask

  task automatic hostRead(input pioReg r);
    logic [`PIO_WIDTH-1:0] img;
    case (r)
      REG_MASK: img = mMask;
      REG_INT:  img = mInt;
      REG_TYPE: img = mType;
      default:  img = mData;
    endcase
    expQ.push_back({~|(mMask & mInt), mType, mData, busImage(img)});
    @(posedge PIOCLK0);
    hostReq <= 1'b1;
    hostOp <= hostCmdPkg::OP_READ;
    hostReg <= r;
    completeRequest();
  endtask

  task automatic holdPins(input logic [`PIO_WIDTH-1:0] newPins);
    mInt = mInt | ((newPins ^ mPins) & ~mType & mMask);
    mPins = newPins;
    mData = (mType & mData) | (~mType & mPins);
    @(posedge PIOCLK0);
    pioIn <= newPins;
    repeat (4) @(posedge PIOCLK0);
  endtask

  task automatic pulseGlitch(input logic [`PIO_WIDTH-1:0] bits);
    @(posedge PIOCLK0);
    pioIn <= mPins ^ bits; // one cycle only.
    @(posedge PIOCLK0);
    pioIn <= mPins;
    repeat (4) @(posedge PIOCLK0);
  endtask

  task automatic waitDrain();
    while (expQ.size() != 0) @(posedge PIOCLK0);
    repeat (4) @(posedge PIOCLK0);
  endtask

  // response side, loads the expected values with the ack.
  initial
  begin
    forever
    begin
      @(posedge PIOCLK0);
      if (rspReq && ackEnable && !rspAck)
      begin
        if (expQ.size() == 0)
        begin
          tbErrors++;
          $display("a response arrived with no read outstanding");
        end
        else
          {expIntN, expEn, expOut, expRsp} <= expQ.pop_front();
        rspAck <= 1'b1;
      end
      else if (!rspReq && rspAck)
        rspAck <= 1'b0;
    end
  end

  initial
  begin
    #(STIM_CYCLES * 8 + MARGIN);
    $display("watchdog expired before the stimulus finished");
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    repeat (8) @(posedge PIOCLK0);
    T_RST <= 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      hostWrite(REG_MASK, 16'($random(seed)));
      hostRead(REG_MASK);
      hostWrite(REG_TYPE, 16'($random(seed)));
      hostRead(REG_TYPE);
    end
    waitDrain();
    hostWrite(REG_TYPE, 16'h30F0); // pins 4 to 9 drive.
    hostRead(REG_TYPE);
    hostWrite(REG_DATA, 16'($random(seed)));
    hostRead(REG_DATA);
    waitDrain();
    // ~~~~~~~~~~~~~~~~~~~~
    // filter and interrupt.
    // ~~~~~~~~~~~~~~~~~~~~
    hostWrite(REG_INT, 16'h0000);
    hostWrite(REG_MASK, 16'h0003);
    hostRead(REG_MASK);
    waitDrain();
    holdPins(12'h004); // unmasked input.
    hostRead(REG_DATA);
    pulseGlitch(12'h001);
    hostRead(REG_DATA);
    hostRead(REG_INT);
    waitDrain();
    holdPins(12'h005);
    hostRead(REG_INT);
    waitDrain();
    hostWrite(REG_INT, 16'h0000);
    hostRead(REG_INT);
    waitDrain();
    // response held off, the FIFO fills behind the read.
    ackEnable <= 1'b0;
    hostRead(REG_DATA);
    hostWrite(REG_MASK, 16'($random(seed)));
    hostWrite(REG_TYPE, 16'($random(seed)));
    hostWrite(REG_DATA, 16'($random(seed)));
    hostWrite(REG_MASK, 16'($random(seed)));
    fork
      hostWrite(REG_DATA, 16'($random(seed)));
      begin
        repeat (2) @(posedge PIOCLK0);
        expStall <= 1'b1;
        repeat (10) @(posedge PIOCLK0);
        expStall <= 1'b0;
        ackEnable <= 1'b1;
      end
    join
    hostRead(REG_MASK);
    hostRead(REG_TYPE);
    hostRead(REG_DATA);
    waitDrain();
    $display("errors: %0d value, %0d protocol, %0d testbench", valErrors, protoErrors,
      tbErrors);
    if (valErrors + protoErrors + tbErrors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- src.f
+incdir+design
design/pioRegPkg.sv
design/hostCmdPkg.sv
design/hostCmdCapture.sv
design/cmdFifo.sv
design/regAccessSeq.sv
design/pioFlags.sv
design/pioTop.sv
verif/pioTbChecks.sv
verif/pioTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = pioTb
FILELIST  = src.f
PASS_MSG  = Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/pio_params.svh
SIM     := obj_dir/V$(TOP)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
